// ==== hw/periph_pkg.sv ====
// Peripheral subsystem shared definitions
// Widths, address map, register offsets, bus structs and bridge states

`default_nettype none

package periph_pkg;

   typedef logic [7:0]  addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  reg_idx_t;

   // Region code sits in address bits 7..6, codes 2 and 3 unmapped
   typedef enum logic [1:0] {
      REGION_SYS  = 2'd0,
      REGION_GPIO = 2'd1
   } region_e;

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we;
   } bus_req_t;

   typedef struct packed {
      data_t rdata;
      logic  err;
   } bus_rsp_t;

   typedef enum logic [1:0] {
      IDLE,
      BUSY,
      RESP
   } bridge_state_e;

   localparam data_t SYS_VERSION        = 32'h0001_0400;
   localparam int    GPIO_WIDTH_DEFAULT = 32;

   //******************************
   // Register offsets
   //******************************
   localparam reg_idx_t SYS_REG_VERSION  = 4'd0;
   localparam reg_idx_t SYS_REG_STATUS   = 4'd1;
   localparam reg_idx_t SYS_REG_SWIRQ    = 4'd2;
   localparam reg_idx_t SYS_REG_NMIVEC   = 4'd3;
   localparam reg_idx_t SYS_REG_MTIME    = 4'd4;
   localparam reg_idx_t SYS_REG_MTIMECMP = 4'd5;

   localparam reg_idx_t GPIO_REG_IN   = 4'd0;
   localparam reg_idx_t GPIO_REG_OUT  = 4'd1;
   localparam reg_idx_t GPIO_REG_OE   = 4'd2;
   localparam reg_idx_t GPIO_REG_MASK = 4'd3;

endpackage

`default_nettype wire

// ==== hw/gpio_block.sv ====
// GPIO block
// Output, output enable, synchronized input and masked input interrupt

`timescale 1ns/1ps
`default_nettype none

module gpio_block
  #(parameter int GPIO_WIDTH = periph_pkg::GPIO_WIDTH_DEFAULT)
   (input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_stb,
    input  wire periph_pkg::bus_req_t i_req,
    output logic                     o_ack,
    output periph_pkg::data_t        o_rdata,
    input  wire [GPIO_WIDTH-1:0]     i_gpio_in,
    output logic [GPIO_WIDTH-1:0]    o_gpio_out,
    output logic [GPIO_WIDTH-1:0]    o_gpio_oe,
    output logic                     o_gpio_irq);

   import periph_pkg::*;

   reg_idx_t              idx;
   logic                  wr_en;
   logic [GPIO_WIDTH-1:0] in_meta;
   logic [GPIO_WIDTH-1:0] in_sync;
   logic [GPIO_WIDTH-1:0] mask;
   data_t                 rd_val;

   assign idx   = i_req.addr[5:2];
   assign wr_en = i_stb & i_req.we;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_ack      <= 1'b0;
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         mask       <= '0;
         in_meta    <= '0;
         in_sync    <= '0;
      end else begin
         o_ack   <= i_stb;
         // Two flops for the asynchronous pins
         in_meta <= i_gpio_in;
         in_sync <= in_meta;
         if (wr_en) begin
            case (idx)
               GPIO_REG_OUT:  o_gpio_out <= i_req.wdata[GPIO_WIDTH-1:0];
               GPIO_REG_OE:   o_gpio_oe  <= i_req.wdata[GPIO_WIDTH-1:0];
               GPIO_REG_MASK: mask       <= i_req.wdata[GPIO_WIDTH-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (idx)
         GPIO_REG_IN:   rd_val = data_t'(in_sync);
         GPIO_REG_OUT:  rd_val = data_t'(o_gpio_out);
         GPIO_REG_OE:   rd_val = data_t'(o_gpio_oe);
         GPIO_REG_MASK: rd_val = data_t'(mask);
         default:       rd_val = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_stb) begin
         o_rdata <= rd_val;
      end
   end

   // Level interrupt from any enabled pin
   assign o_gpio_irq = |(in_sync & mask);

endmodule

`default_nettype wire

// ==== hw/sys_ctrl.sv ====
// System controller
// Version, RAM init status, software interrupts, NMI vector, machine timer

`timescale 1ns/1ps
`default_nettype none

module sys_ctrl
   (input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_stb,
    input  wire periph_pkg::bus_req_t i_req,
    output logic                     o_ack,
    output periph_pkg::data_t        o_rdata,
    input  wire                      i_ram_init_done,
    input  wire                      i_ram_init_error,
    output logic                     o_timer_irq,
    output logic                     o_sw_irq3,
    output logic                     o_sw_irq4,
    output periph_pkg::data_t        o_nmi_vec);

   import periph_pkg::*;

   reg_idx_t   idx;
   logic       wr_en;
   logic [1:0] sw_irq;
   data_t      mtime;
   data_t      mtimecmp;
   data_t      rd_val;

   assign idx   = i_req.addr[5:2];
   assign wr_en = i_stb & i_req.we;

   //******************************
   // Writable registers and timer
   //******************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_ack     <= 1'b0;
         sw_irq    <= 2'b00;
         o_nmi_vec <= '0;
         mtime     <= '0;
         mtimecmp  <= '1;
      end else begin
         o_ack <= i_stb;
         // Free running unless software loads it
         if (wr_en && (idx == SYS_REG_MTIME)) begin
            mtime <= i_req.wdata;
         end else begin
            mtime <= mtime + 32'd1;
         end
         if (wr_en) begin
            case (idx)
               SYS_REG_SWIRQ:    sw_irq    <= i_req.wdata[1:0];
               SYS_REG_NMIVEC:   o_nmi_vec <= i_req.wdata;
               SYS_REG_MTIMECMP: mtimecmp  <= i_req.wdata;
               default: ;
            endcase
         end
      end
   end

   // Read mux
   always_comb begin
      case (idx)
         SYS_REG_VERSION:  rd_val = SYS_VERSION;
         SYS_REG_STATUS:   rd_val = {30'd0, i_ram_init_error, i_ram_init_done};
         SYS_REG_SWIRQ:    rd_val = {30'd0, sw_irq};
         SYS_REG_NMIVEC:   rd_val = o_nmi_vec;
         SYS_REG_MTIME:    rd_val = mtime;
         SYS_REG_MTIMECMP: rd_val = mtimecmp;
         default:          rd_val = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_stb) begin
         o_rdata <= rd_val;
      end
   end

   assign o_timer_irq = (mtime >= mtimecmp);
   assign o_sw_irq3   = sw_irq[0];
   assign o_sw_irq4   = sw_irq[1];

endmodule

`default_nettype wire

// ==== hw/addr_decode.sv ====
// Internal bus address decoder
// Routes the strobe by region, muxes replies, errors on unmapped regions

`timescale 1ns/1ps
`default_nettype none

module addr_decode
   (input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_bus_stb,
    input  wire periph_pkg::addr_t i_bus_addr,
    output logic                   o_bus_ack,
    output periph_pkg::data_t      o_bus_rdata,
    output logic                   o_bus_err,
    output logic                   o_sys_stb,
    input  wire                    i_sys_ack,
    input  wire periph_pkg::data_t i_sys_rdata,
    output logic                   o_gpio_stb,
    input  wire                    i_gpio_ack,
    input  wire periph_pkg::data_t i_gpio_rdata);

   import periph_pkg::*;

   region_e region;
   logic    unmapped;
   logic    err_ack;

   assign region     = region_e'(i_bus_addr[7:6]);
   assign o_sys_stb  = i_bus_stb & (region == REGION_SYS);
   assign o_gpio_stb = i_bus_stb & (region == REGION_GPIO);
   assign unmapped   = (region != REGION_SYS) && (region != REGION_GPIO);

   // Own ack for holes in the map, same latency as a slave
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         err_ack <= 1'b0;
      end else begin
         err_ack <= i_bus_stb & unmapped;
      end
   end

   always_comb begin
      o_bus_rdata = '0;
      if (i_sys_ack) begin
         o_bus_rdata = i_sys_rdata;
      end else if (i_gpio_ack) begin
         o_bus_rdata = i_gpio_rdata;
      end
   end

   assign o_bus_ack = i_sys_ack | i_gpio_ack | err_ack;
   assign o_bus_err = err_ack;

endmodule

`default_nettype wire

// ==== hw/bus_bridge.sv ====
// Request/response bridge to the internal register bus
// One transaction in flight, response held until the master takes it

`timescale 1ns/1ps
`default_nettype none

module bus_bridge
   (input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_req_valid,
    input  wire periph_pkg::bus_req_t i_req,
    output logic                     o_req_ready,
    output logic                     o_rsp_valid,
    output periph_pkg::bus_rsp_t     o_rsp,
    input  wire                      i_rsp_ready,
    output logic                     o_bus_stb,
    output periph_pkg::bus_req_t     o_bus_req,
    input  wire                      i_bus_ack,
    input  wire periph_pkg::data_t   i_bus_rdata,
    input  wire                      i_bus_err);

   import periph_pkg::*;

   bridge_state_e state;
   bridge_state_e state_nxt;
   logic          accept;

   assign o_req_ready = (state == IDLE);
   assign o_rsp_valid = (state == RESP);
   assign accept      = i_req_valid & o_req_ready;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (accept) begin
               state_nxt = BUSY;
            end
         end
         BUSY: begin
            // Slave ack comes one cycle after the strobe
            if (i_bus_ack) begin
               state_nxt = RESP;
            end
         end
         RESP: begin
            if (i_rsp_ready) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state     <= IDLE;
         o_bus_stb <= 1'b0;
      end else begin
         state     <= state_nxt;
         o_bus_stb <= accept;
      end
   end

   //******************************
   // Request and response payload
   //******************************
   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_bus_req <= i_req;
      end
      if ((state == BUSY) && i_bus_ack) begin
         o_rsp.rdata <= i_bus_rdata;
         o_rsp.err   <= i_bus_err;
      end
   end

endmodule

`default_nettype wire

// ==== hw/periph_subsys.sv ====
// Peripheral subsystem top level
// Request bridge, address decoder, system controller and GPIO block

`timescale 1ns/1ps
`default_nettype none

module periph_subsys
  #(parameter int GPIO_WIDTH = periph_pkg::GPIO_WIDTH_DEFAULT)
   (input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_req_valid,
    input  wire periph_pkg::bus_req_t i_req,
    output logic                     o_req_ready,
    output logic                     o_rsp_valid,
    output periph_pkg::bus_rsp_t     o_rsp,
    input  wire                      i_rsp_ready,
    input  wire                      i_ram_init_done,
    input  wire                      i_ram_init_error,
    output logic                     o_timer_irq,
    output logic                     o_sw_irq3,
    output logic                     o_sw_irq4,
    output periph_pkg::data_t        o_nmi_vec,
    input  wire [GPIO_WIDTH-1:0]     i_gpio_in,
    output logic [GPIO_WIDTH-1:0]    o_gpio_out,
    output logic [GPIO_WIDTH-1:0]    o_gpio_oe,
    output logic                     o_gpio_irq);

   import periph_pkg::*;

   // Internal bus
   logic     bus_stb;
   bus_req_t bus_req;
   logic     bus_ack;
   data_t    bus_rdata;
   logic     bus_err;

   logic     sys_stb;
   logic     sys_ack;
   data_t    sys_rdata;
   logic     gpio_stb;
   logic     gpio_ack;
   data_t    gpio_rdata;

   bus_bridge u_bridge
     (.i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .o_req_ready (o_req_ready),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .i_rsp_ready (i_rsp_ready),
      .o_bus_stb   (bus_stb),
      .o_bus_req   (bus_req),
      .i_bus_ack   (bus_ack),
      .i_bus_rdata (bus_rdata),
      .i_bus_err   (bus_err));

   addr_decode u_decode
     (.i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_bus_stb    (bus_stb),
      .i_bus_addr   (bus_req.addr),
      .o_bus_ack    (bus_ack),
      .o_bus_rdata  (bus_rdata),
      .o_bus_err    (bus_err),
      .o_sys_stb    (sys_stb),
      .i_sys_ack    (sys_ack),
      .i_sys_rdata  (sys_rdata),
      .o_gpio_stb   (gpio_stb),
      .i_gpio_ack   (gpio_ack),
      .i_gpio_rdata (gpio_rdata));

   sys_ctrl u_sys
     (.i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_stb            (sys_stb),
      .i_req            (bus_req),
      .o_ack            (sys_ack),
      .o_rdata          (sys_rdata),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_timer_irq      (o_timer_irq),
      .o_sw_irq3        (o_sw_irq3),
      .o_sw_irq4        (o_sw_irq4),
      .o_nmi_vec        (o_nmi_vec));

   gpio_block
     #(.GPIO_WIDTH (GPIO_WIDTH))
   u_gpio
     (.i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_stb      (gpio_stb),
      .i_req      (bus_req),
      .o_ack      (gpio_ack),
      .o_rdata    (gpio_rdata),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (o_gpio_irq));

endmodule

`default_nettype wire

// ==== bench/periph_sva.sv ====
// Bridge handshake assertions
// Bound into every bus_bridge instance

`timescale 1ns/1ps
`default_nettype none

module periph_sva
   (input wire                            i_clk,
    input wire                            i_rst_n,
    input wire periph_pkg::bridge_state_e i_state,
    input wire                            i_req_valid,
    input wire                            i_req_ready,
    input wire                            i_rsp_valid,
    input wire periph_pkg::bus_rsp_t      i_rsp,
    input wire                            i_rsp_ready,
    input wire                            i_bus_stb);

   import periph_pkg::*;

   // Ready stays low from acceptance until the response transfers
   a_ready_only_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      ((i_req_valid && i_req_ready) ||
       ((i_state != IDLE) && !(i_rsp_valid && i_rsp_ready))) |=> !i_req_ready)
      else $error("request ready outside IDLE");

   // Held response must not move until taken
   a_rsp_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp)))
      else $error("response changed under back-pressure");

   a_stb_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_bus_stb |=> !i_bus_stb)
      else $error("bus strobe longer than one cycle");

endmodule

bind bus_bridge periph_sva u_sva
   (.i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_state     (state),
    .i_req_valid (i_req_valid),
    .i_req_ready (o_req_ready),
    .i_rsp_valid (o_rsp_valid),
    .i_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready),
    .i_bus_stb   (o_bus_stb));

`default_nettype wire

// ==== bench/periph_tb.sv ====
// Peripheral subsystem testbench
// Table of register accesses run without and then with back-pressure

`timescale 1ns/1ps
`default_nettype none

module periph_tb;

   import periph_pkg::*;

   localparam int   GPIO_WIDTH = GPIO_WIDTH_DEFAULT;
   localparam logic WR = 1'b1;
   localparam logic RD = 1'b0;

   typedef struct packed {
      logic       we;
      addr_t      addr;
      data_t      wdata;
      data_t      exp_rdata;
      logic       exp_err;
      data_t      pins;
      logic [1:0] ram;
      logic [3:0] exp_irq;
   } entry_t;

   logic                  i_clk = 1'b0;
   logic                  i_rst_n;
   logic                  i_req_valid;
   bus_req_t              i_req;
   logic                  o_req_ready;
   logic                  o_rsp_valid;
   bus_rsp_t              o_rsp;
   logic                  i_rsp_ready;
   logic                  i_ram_init_done;
   logic                  i_ram_init_error;
   logic                  o_timer_irq;
   logic                  o_sw_irq3;
   logic                  o_sw_irq4;
   data_t                 o_nmi_vec;
   logic [GPIO_WIDTH-1:0] i_gpio_in;
   logic [GPIO_WIDTH-1:0] o_gpio_out;
   logic [GPIO_WIDTH-1:0] o_gpio_oe;
   logic                  o_gpio_irq;

   entry_t                entries[$];
   logic                  table_built = 1'b0;
   logic                  backpressure;
   int                    errors = 0;
   int                    tests = 0;
   int                    failed = 0;
   logic [GPIO_WIDTH-1:0] exp_out;
   logic [GPIO_WIDTH-1:0] exp_oe;
   data_t                 exp_nmi;

   periph_subsys #(.GPIO_WIDTH (GPIO_WIDTH)) DUT (.*);

   always #50 i_clk = ~i_clk;

   //******************************
   // Helpers
   //******************************
   function automatic addr_t sys_reg(input reg_idx_t idx);
      return {2'd0, idx, 2'b00};
   endfunction

   function automatic addr_t gpio_reg(input reg_idx_t idx);
      return {2'd1, idx, 2'b00};
   endfunction

   task automatic add_entry(input logic we, input addr_t addr, input data_t wdata,
                            input data_t rdata, input logic err, input data_t pins,
                            input logic [1:0] ram, input logic [3:0] irq);
      entry_t e;
      e = '{we, addr, wdata, rdata, err, pins, ram, irq};
      entries.push_back(e);
   endtask

   task automatic next_cycle();
      @(posedge i_clk);
      #1;
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_gpio(input string name, input logic [GPIO_WIDTH-1:0] got,
                             input logic [GPIO_WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("%s: ok", name);
      end else begin
         failed++;
         $display("%s: FAILED", name);
      end
   endtask

   // Irq order in the table is timer, sw4, sw3, gpio
   task automatic build_table();
      add_entry(RD, sys_reg(SYS_REG_VERSION), '0, SYS_VERSION, 1'b0, '0, 2'b00, 4'h0);
      add_entry(WR, gpio_reg(GPIO_REG_OUT), 32'hA5A5_00FF, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, gpio_reg(GPIO_REG_OUT), '0, 32'hA5A5_00FF, 1'b0, '0, 2'b00, 4'h0);
      add_entry(WR, gpio_reg(GPIO_REG_OE), 32'h0000_FFFF, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, gpio_reg(GPIO_REG_OE), '0, 32'h0000_FFFF, 1'b0, '0, 2'b00, 4'h0);
      add_entry(WR, gpio_reg(GPIO_REG_MASK), 32'h0000_0011, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, gpio_reg(GPIO_REG_MASK), '0, 32'h0000_0011, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, gpio_reg(GPIO_REG_IN), '0, 32'h10, 1'b0, 32'h10, 2'b00, 4'h1);
      add_entry(RD, gpio_reg(GPIO_REG_IN), '0, 32'h22, 1'b0, 32'h22, 2'b00, 4'h0);
      add_entry(RD, gpio_reg(GPIO_REG_IN), '0, 32'h8000_0001, 1'b0, 32'h8000_0001, 2'b00, 4'h1);
      add_entry(WR, gpio_reg(GPIO_REG_MASK), '0, '0, 1'b0, 32'h8000_0001, 2'b00, 4'h0);
      add_entry(RD, gpio_reg(GPIO_REG_IN), '0, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(WR, sys_reg(SYS_REG_SWIRQ), 32'h1, '0, 1'b0, '0, 2'b00, 4'h2);
      add_entry(RD, sys_reg(SYS_REG_SWIRQ), '0, 32'h1, 1'b0, '0, 2'b00, 4'h2);
      add_entry(WR, sys_reg(SYS_REG_SWIRQ), 32'h2, '0, 1'b0, '0, 2'b00, 4'h4);
      add_entry(RD, sys_reg(SYS_REG_SWIRQ), '0, 32'h2, 1'b0, '0, 2'b00, 4'h4);
      add_entry(WR, sys_reg(SYS_REG_SWIRQ), '0, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(WR, sys_reg(SYS_REG_NMIVEC), 32'h8000_0100, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, sys_reg(SYS_REG_NMIVEC), '0, 32'h8000_0100, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, sys_reg(SYS_REG_STATUS), '0, 32'h1, 1'b0, '0, 2'b01, 4'h0);
      add_entry(RD, sys_reg(SYS_REG_STATUS), '0, 32'h2, 1'b0, '0, 2'b10, 4'h0);
      add_entry(RD, sys_reg(SYS_REG_STATUS), '0, 32'h3, 1'b0, '0, 2'b11, 4'h0);
      add_entry(WR, sys_reg(SYS_REG_VERSION), 32'hDEAD_BEEF, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, sys_reg(SYS_REG_VERSION), '0, SYS_VERSION, 1'b0, '0, 2'b00, 4'h0);
      add_entry(WR, sys_reg(SYS_REG_MTIMECMP), '0, '0, 1'b0, '0, 2'b00, 4'h8);
      add_entry(RD, sys_reg(SYS_REG_MTIMECMP), '0, '0, 1'b0, '0, 2'b00, 4'h8);
      add_entry(WR, sys_reg(SYS_REG_MTIME), '0, '0, 1'b0, '0, 2'b00, 4'h8);
      add_entry(WR, sys_reg(SYS_REG_MTIMECMP), '1, '0, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, sys_reg(SYS_REG_MTIMECMP), '0, '1, 1'b0, '0, 2'b00, 4'h0);
      // Holes in the map whose writes alias NMIVEC and OUT by index
      add_entry(RD, 8'h84, '0, '0, 1'b1, '0, 2'b00, 4'h0);
      add_entry(WR, 8'h8C, 32'h1234_5678, '0, 1'b1, '0, 2'b00, 4'h0);
      add_entry(WR, 8'hC4, '0, '0, 1'b1, '0, 2'b00, 4'h0);
      add_entry(RD, 8'hCC, '0, '0, 1'b1, '0, 2'b00, 4'h0);
      add_entry(RD, gpio_reg(GPIO_REG_OUT), '0, 32'hA5A5_00FF, 1'b0, '0, 2'b00, 4'h0);
      add_entry(RD, sys_reg(SYS_REG_NMIVEC), '0, 32'h8000_0100, 1'b0, '0, 2'b00, 4'h0);
   endtask

   //******************************
   // Bus access and table entries
   //******************************
   task automatic apply_reset();
      i_rst_n     = 1'b0;
      i_req_valid = 1'b0;
      i_rsp_ready = 1'b0;
      repeat (3) next_cycle();
      i_rst_n = 1'b1;
      exp_out = '0;
      exp_oe  = '0;
      exp_nmi = '0;
   endtask

   task automatic do_access(input bus_req_t req, output data_t rdata, output logic err);
      logic [31:0] rnd;
      logic        done;
      i_req_valid = 1'b1;
      i_req       = req;
      while (!o_req_ready) begin
         next_cycle();
      end
      next_cycle();
      i_req_valid = 1'b0;
      done = 1'b0;
      while (!done) begin
         rnd = $urandom;
         i_rsp_ready = backpressure ? rnd[0] : 1'b1;
         if (o_rsp_valid && i_rsp_ready) begin
            rdata = o_rsp.rdata;
            err   = o_rsp.err;
            done  = 1'b1;
         end else if (o_req_ready) begin
            $display("Request ready again at %0t before the response transferred", $time);
            errors++;
         end
         next_cycle();
      end
      i_rsp_ready = 1'b0;
   endtask

   task automatic run_entry(input entry_t e);
      data_t    rdata;
      logic     err;
      bus_req_t req;
      {i_ram_init_error, i_ram_init_done} = e.ram;
      if (i_gpio_in != e.pins[GPIO_WIDTH-1:0]) begin
         i_gpio_in = e.pins[GPIO_WIDTH-1:0];
         // Let the pin pass the synchronizer
         repeat (3) next_cycle();
      end
      req.addr  = e.addr;
      req.wdata = e.wdata;
      req.we    = e.we;
      do_access(req, rdata, err);
      if (e.we && !e.exp_err && (e.addr[7:6] == REGION_GPIO)) begin
         if (e.addr[5:2] == GPIO_REG_OUT) begin
            exp_out = e.wdata[GPIO_WIDTH-1:0];
         end else if (e.addr[5:2] == GPIO_REG_OE) begin
            exp_oe = e.wdata[GPIO_WIDTH-1:0];
         end
      end
      if (e.we && !e.exp_err && (e.addr[7:6] == REGION_SYS) &&
          (e.addr[5:2] == SYS_REG_NMIVEC)) begin
         exp_nmi = e.wdata;
      end
      if (!e.we || e.exp_err) begin
         check_data("o_rsp.rdata", rdata, e.exp_rdata);
      end
      check_err("o_rsp.err", err, e.exp_err);
      check_err("o_timer_irq", o_timer_irq, e.exp_irq[3]);
      check_err("o_sw_irq4", o_sw_irq4, e.exp_irq[2]);
      check_err("o_sw_irq3", o_sw_irq3, e.exp_irq[1]);
      check_err("o_gpio_irq", o_gpio_irq, e.exp_irq[0]);
      check_gpio("o_gpio_out", o_gpio_out, exp_out);
      check_gpio("o_gpio_oe", o_gpio_oe, exp_oe);
      check_data("o_nmi_vec", o_nmi_vec, exp_nmi);
   endtask

   //******************************
   // Main sequence
   //******************************
   initial begin
      int       errs_before;
      data_t    t0;
      data_t    t1;
      logic     err;
      bus_req_t req;
      i_rst_n          = 1'b0;
      i_req_valid      = 1'b0;
      i_req            = '0;
      i_rsp_ready      = 1'b0;
      i_ram_init_done  = 1'b0;
      i_ram_init_error = 1'b0;
      i_gpio_in        = '0;
      backpressure     = 1'b0;
      void'($urandom(85090));
      build_table();
      table_built = 1'b1;
      for (int pass = 0; pass < 2; pass++) begin
         backpressure = (pass == 1);
         apply_reset();
         errs_before = errors;
         check_err("o_req_ready", o_req_ready, 1'b1);
         check_err("o_rsp_valid", o_rsp_valid, 1'b0);
         check_err("o_timer_irq", o_timer_irq, 1'b0);
         check_err("o_sw_irq3", o_sw_irq3, 1'b0);
         check_err("o_sw_irq4", o_sw_irq4, 1'b0);
         check_err("o_gpio_irq", o_gpio_irq, 1'b0);
         check_gpio("o_gpio_out", o_gpio_out, '0);
         check_gpio("o_gpio_oe", o_gpio_oe, '0);
         check_data("o_nmi_vec", o_nmi_vec, '0);
         report_test($sformatf("pass %0d reset values", pass), errs_before);
         for (int i = 0; i < entries.size(); i++) begin
            errs_before = errors;
            run_entry(entries[i]);
            report_test($sformatf("pass %0d entry %0d", pass, i), errs_before);
         end
         // Timer keeps counting after a load
         errs_before = errors;
         req = '{addr: sys_reg(SYS_REG_MTIME), wdata: '0, we: 1'b1};
         do_access(req, t0, err);
         check_err("o_rsp.err", err, 1'b0);
         req.we = 1'b0;
         do_access(req, t0, err);
         check_err("o_rsp.err", err, 1'b0);
         do_access(req, t1, err);
         check_err("o_rsp.err", err, 1'b0);
         if ((t1 >= t0) !== 1'b1) begin
            $display("FAIL %0t mtime: got %h, expected at least %h", $time, t1, t0);
            errors++;
         end
         report_test($sformatf("pass %0d mtime reads", pass), errs_before);
      end
      $display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      int limit;
      wait (table_built);
      limit = entries.size() * 20 + 100;
      repeat (limit) @(posedge i_clk);
      $display("Timeout after %0d cycles, the DUT stopped answering", limit);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/periph_pkg.sv
hw/gpio_block.sv
hw/sys_ctrl.sv
hw/addr_decode.sv
hw/bus_bridge.sv
hw/periph_subsys.sv
bench/periph_sva.sv
bench/periph_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= periph_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o sim
	@out="$$(./$(OBJ_DIR)/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
